// File: files.f
+incdir+bench
common/bp_pkg.sv
hw/btb/btb_4way.sv
hw/local_predictor/local_branch_predictor.sv
hw/branch_predictor.sv
bench/tb_branch_predictor.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it into sim.log and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_branch_predictor -Mdir obj_dir -f files.f \
    && ./obj_dir/Vtb_branch_predictor > sim.log 2>&1 \
    || { echo "build or simulation run failed, see sim.log"; exit 1; }

grep -q "=== PASS ===" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: bench/bp_model.svh
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

// reference copy of the predictor state, updated on the same edge as the dut
logic              m_vld   [n_sets][btb_ways];
pc_t               m_tag   [n_sets][btb_ways];      // upper pc bits, zero extended
pc_t               m_tgt   [n_sets][btb_ways];
logic              m_root  [n_sets];                // 0 means the victim lies in ways 0..1
logic              m_left  [n_sets];                // 0 means way 0
logic              m_right [n_sets];                // 0 means way 2
logic [n_hist-1:0] m_hist  [n_bht];
cnt_state_t        m_cnt   [1 << n_hist];

function automatic int set_of(input pc_t pc);
    return int'((pc >> 2) % n_sets);
endfunction

function automatic pc_t tag_of(input pc_t pc);
    return pc >> (2 + $clog2(n_sets));
endfunction

function automatic int slot_of(input pc_t pc);
    return int'((pc >> 2) % n_bht);
endfunction

task automatic model_reset();
    for (int s = 0; s < n_sets; s++) begin
        m_root[s]  = 1'b0;
        m_left[s]  = 1'b0;
        m_right[s] = 1'b0;
        for (int w = 0; w < btb_ways; w++) begin
            m_vld[s][w] = 1'b0;
            m_tag[s][w] = '0;
            m_tgt[s][w] = '0;
        end
    end
    for (int i = 0; i < n_bht; i++) begin
        m_hist[i] = '0;
    end
    for (int i = 0; i < (1 << n_hist); i++) begin
        m_cnt[i] = weak_nt;
    end
endtask

task automatic model_update(input pc_t pc, input logic taken, input pc_t tgt);
    int s;
    int b;
    int way;
    int h;
    s   = set_of(pc);
    b   = slot_of(pc);
    way = -1;
    for (int w = 0; w < btb_ways; w++) begin
        if (m_vld[s][w] && m_tag[s][w] == tag_of(pc)) begin
            way = w;                                    // hit, rewrite in place
        end
    end
    for (int w = 0; w < btb_ways; w++) begin
        if (way < 0 && !m_vld[s][w]) begin
            way = w;                                    // first free way
        end
    end
    if (way < 0) begin
        way = m_root[s] ? (m_right[s] ? 3 : 2) : (m_left[s] ? 1 : 0);
    end
    m_vld[s][way] = 1'b1;
    m_tag[s][way] = tag_of(pc);
    m_tgt[s][way] = tgt;
    m_root[s] = (way < 2);                              // point at the other pair
    if (way < 2) begin
        m_left[s] = (way == 0);
    end else begin
        m_right[s] = (way == 2);
    end
    h = int'(m_hist[b]);                                // counter picked by the old history
    if (taken && m_cnt[h] != strong_t) begin
        m_cnt[h] = cnt_state_t'(m_cnt[h] + 2'd1);
    end else if (!taken && m_cnt[h] != strong_nt) begin
        m_cnt[h] = cnt_state_t'(m_cnt[h] - 2'd1);
    end
    m_hist[b] = {m_hist[b][n_hist-2:0], taken};
endtask

// expected next fetch pc, target only on a btb hit with a taken counter
function automatic pc_t model_predict(input pc_t pc);
    int s;
    pc_t nxt;
    s   = set_of(pc);
    nxt = pc + 32'd4;
    for (int w = 0; w < btb_ways; w++) begin
        if (m_vld[s][w] && m_tag[s][w] == tag_of(pc) && m_cnt[m_hist[slot_of(pc)]] >= weak_t) begin
            nxt = m_tgt[s][w];
        end
    end
    return nxt;
endfunction

`endif

// File: bench/tb_branch_predictor.sv
`timescale 1ns/1ns

module tb_branch_predictor
    import bp_pkg::*;
();

    localparam int n_sets     = default_btb_sets;
    localparam int n_bht      = default_bht_entries;
    localparam int n_hist     = default_hist_bits;
    localparam int n_updates  = 8 + 24 + 25 + 7 + 200;   // strobes over all tests
    localparam int n_lookups  = 32 + 8 + 24 + 5 + 2 + 200;
    localparam int timeout_ns = (n_updates + n_lookups + 100) * 10;

    logic        clk;
    logic        rst_n;
    pc_t         predict_pc;
    pc_t         update_pc;
    logic        valid;
    logic        branch_taken;
    pc_t         target_pc;
    pc_t         predicted_pc;

    int          errors;
    logic [31:0] lfsr_q;                                // random source state
    pc_t         last_act;                              // dut answer of the latest lookup
    pc_t         pool [12];                             // branch pcs for the random mix

    `include "bp_model.svh"

    branch_predictor #(
        .btb_sets    (n_sets),
        .bht_entries (n_bht),
        .hist_bits   (n_hist)
    ) dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .predict_pc   (predict_pc),
        .update_pc    (update_pc),
        .valid        (valid),
        .branch_taken (branch_taken),
        .target_pc    (target_pc),
        .predicted_pc (predicted_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                          // 10 ns period
    end

    // galois step, one call per random bit
    function automatic logic next_bit();
        logic b;
        b      = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic pc_t rand_pc();
        pc_t v;
        v = rand_bits(30);
        return v << 2;                                  // word aligned
    endfunction

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (exp !== act) begin
            errors++;
            $display("Error %s expected %h actual %h", name, exp, act);
        end
    endtask

    // entered 1 ns after an edge, the strobe is taken on the next edge
    task automatic drive_update(input pc_t pc, input logic taken, input pc_t tgt);
        update_pc    = pc;
        branch_taken = taken;
        target_pc    = tgt;
        valid        = 1'b1;
        @(posedge clk);
        model_update(pc, taken, tgt);                   // same edge as the dut
        #1;
        valid = 1'b0;
    endtask

    // combinational lookup, sampled at the falling edge
    task automatic check_lookup(input string name, input pc_t pc);
        pc_t exp;
        predict_pc = pc;
        @(negedge clk);
        exp      = model_predict(pc);
        last_act = predicted_pc;
        check_pc(name, exp, last_act);
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset_default();
        pc_t pc;
        for (int i = 0; i < 32; i++) begin
            pc = rand_pc();
            check_lookup("test_reset_default", pc);
            check_pc("test_reset_default", pc + 32'd4, last_act);   // empty tables
        end
    endtask

    task automatic test_always_taken();
        pc_t pc;
        pc_t tgt;
        pc  = 32'h0000_1040;                            // set 0, history slot 16
        tgt = 32'h0000_3000;
        for (int i = 0; i < 8; i++) begin
            drive_update(pc, 1'b1, tgt);
            check_lookup("test_always_taken", pc);
        end
        check_pc("test_always_taken", tgt, last_act);   // saturated by now
    endtask

    task automatic test_alternating_pattern();
        pc_t  pc;
        pc_t  tgt;
        logic taken;
        pc  = 32'h0000_1184;                            // set 1, history slot 33
        tgt = 32'h0000_4000;
        for (int i = 0; i < 24; i++) begin
            taken = (i % 2 == 0);
            check_lookup("test_alternating_pattern", pc);
            if (i >= 12) begin
                check_pc("test_alternating_pattern", taken ? tgt : pc + 32'd4, last_act);
            end
            drive_update(pc, taken, tgt);
        end
    endtask

    task automatic test_btb_eviction();
        pc_t pc;
        for (int b = 0; b < 5; b++) begin
            pc = 32'h0000_2014 + 32'h400 * b;           // all in set 5, distinct tags
            repeat (5) drive_update(pc, 1'b1, 32'h0000_5000 + 32'h10 * b);
        end
        for (int b = 0; b < 5; b++) begin
            pc = 32'h0000_2014 + 32'h400 * b;
            check_lookup("test_btb_eviction", pc);
            check_pc("test_btb_eviction", (b == 0) ? pc + 32'd4 : 32'h0000_5000 + 32'h10 * b,
                     last_act);                         // first branch was the victim
        end
    endtask

    task automatic test_target_rewrite_and_miss();
        pc_t pc_a;
        pc_t pc_b;
        pc_a = 32'h0000_3028;
        pc_b = 32'h0000_3128;                           // same history slot and set, new tag
        repeat (6) drive_update(pc_a, 1'b1, 32'h0000_7000);
        drive_update(pc_a, 1'b1, 32'h0000_7100);
        check_lookup("test_target_rewrite_and_miss", pc_a);
        check_pc("test_target_rewrite_and_miss", 32'h0000_7100, last_act);
        check_lookup("test_target_rewrite_and_miss", pc_b);
        check_pc("test_target_rewrite_and_miss", pc_b + 32'd4, last_act);
    endtask

    task automatic test_random_mix();
        pc_t  pc;
        pc_t  tgt;
        logic taken;
        for (int k = 0; k < 12; k++) begin
            pool[k] = rand_pc();
        end
        for (int i = 0; i < 200; i++) begin
            pc    = pool[int'(rand_bits(4) % 12)];
            taken = next_bit();
            tgt   = rand_pc();
            drive_update(pc, taken, tgt);
            check_lookup("test_random_mix", pool[int'(rand_bits(4) % 12)]);
        end
    endtask

    initial begin
        #(timeout_ns);
        $display("timeout, tests did not finish within %0d ns", timeout_ns);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        errors       = 0;
        lfsr_q       = 32'hd96e_733a;
        rst_n        = 1'b0;
        valid        = 1'b0;
        branch_taken = 1'b0;
        predict_pc   = '0;
        update_pc    = '0;
        target_pc    = '0;
        last_act     = '0;
        model_reset();
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_default();
        test_always_taken();
        test_alternating_pattern();
        test_btb_eviction();
        test_target_rewrite_and_miss();
        test_random_mix();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: hw/branch_predictor.sv
`timescale 1ns/1ns

module branch_predictor
    import bp_pkg::*;
#(
    parameter int btb_sets    = default_btb_sets,
    parameter int bht_entries = default_bht_entries,
    parameter int hist_bits   = default_hist_bits
) (
    input  logic clk,
    input  logic rst_n,
    input  pc_t  predict_pc,                        // fetch pc of IF stage
    input  pc_t  update_pc,                         // branch pc of EX stage
    input  logic valid,                             // branch, jal, jalr resolved in EX
    input  logic branch_taken,                      // resolved direction
    input  pc_t  target_pc,                         // resolved target address
    output pc_t  predicted_pc                       // next fetch pc
);

    pc_t  predicted_target;                         // target held in the btb
    logic target_hit;                               // btb has an entry for predict_pc
    logic predict_taken;                            // direction predictor says taken

    btb_4way #(.btb_sets(btb_sets)) btb_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .predict_pc       (predict_pc),
        .update_pc        (update_pc),
        .valid            (valid),
        .target_pc        (target_pc),
        .predicted_target (predicted_target),
        .target_hit       (target_hit)
    );

    local_branch_predictor #(
        .bht_entries (bht_entries),
        .hist_bits   (hist_bits)
    ) lbp_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .predict_pc    (predict_pc),
        .update_pc     (update_pc),
        .valid         (valid),
        .branch_taken  (branch_taken),
        .predict_taken (predict_taken)
    );

    // redirect only when a target is known and the branch looks taken
    assign predicted_pc = (target_hit && predict_taken) ? predicted_target
                                                        : predict_pc + pc_t'(4);

    // aligned fetch must stay aligned through either path, which relies on aligned btb fills
    a_pc_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        (predict_pc[1:0] == 2'b00) |-> (predicted_pc[1:0] == 2'b00)
    ) else $error("predicted pc lost word alignment");

endmodule

// File: hw/local_predictor/local_branch_predictor.sv
`timescale 1ns/1ns

module local_branch_predictor
    import bp_pkg::*;
#(
    parameter int bht_entries = default_bht_entries,
    parameter int hist_bits   = default_hist_bits
) (
    input  logic clk,
    input  logic rst_n,
    input  pc_t  predict_pc,                        // fetch pc from IF
    input  pc_t  update_pc,                         // resolved branch pc from EX
    input  logic valid,                             // resolved branch strobe
    input  logic branch_taken,                      // actual outcome from EX
    output logic predict_taken                      // direction guess for predict_pc
);

    localparam int bht_idx_w   = idx_bits(bht_entries);
    localparam int cnt_entries = 1 << hist_bits;    // one counter per history pattern

    logic [hist_bits-1:0] hist_q [bht_entries];     // local history per branch slot
    cnt_state_t           cnt_q  [cnt_entries];     // shared pattern table

    logic [bht_idx_w-1:0] pred_idx;
    logic [hist_bits-1:0] pred_hist;
    cnt_state_t           pred_cnt;

    logic [bht_idx_w-1:0] upd_idx;
    logic [hist_bits-1:0] upd_hist;                 // old history of the updating branch
    cnt_state_t           upd_cnt;
    cnt_state_t           upd_cnt_next;
    logic [hist_bits-1:0] upd_hist_next;

    // one saturating step toward the observed outcome
    function automatic cnt_state_t cnt_step(input cnt_state_t cur, input logic taken);
        cnt_state_t nxt;
        case (cur)
            strong_nt: nxt = taken ? weak_nt  : strong_nt;
            weak_nt:   nxt = taken ? weak_t   : strong_nt;
            weak_t:    nxt = taken ? strong_t : weak_nt;
            default:   nxt = taken ? strong_t : weak_t;     // strong_t
        endcase
        return nxt;
    endfunction

    // lookup, history of the fetch pc picks the counter
    assign pred_idx      = predict_pc[bht_idx_w+1:2];
    assign pred_hist     = hist_q[pred_idx];
    assign pred_cnt      = cnt_q[pred_hist];
    assign predict_taken = pred_cnt[1];             // msb means taken

    // update uses the history as it was before this branch
    assign upd_idx       = update_pc[bht_idx_w+1:2];
    assign upd_hist      = hist_q[upd_idx];
    assign upd_cnt       = cnt_q[upd_hist];
    assign upd_cnt_next  = cnt_step(upd_cnt, branch_taken);
    assign upd_hist_next = hist_bits'({upd_hist, branch_taken});   // shift in at lsb

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < bht_entries; i++) begin
                hist_q[i] <= '0;
            end
        end else if (valid) begin
            hist_q[upd_idx] <= upd_hist_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < cnt_entries; i++) begin
                cnt_q[i] <= weak_nt;
            end
        end else if (valid) begin
            cnt_q[upd_hist] <= upd_cnt_next;
        end
    end

    // every counter stays a known state once reset has run
    for (genvar i = 0; i < cnt_entries; i++) begin : g_cnt_chk
        a_cnt_known : assert property (
            @(posedge clk) disable iff (!rst_n) !$isunknown(cnt_q[i])
        ) else $error("pattern counter %0d holds an unknown value", i);
    end

endmodule

// File: hw/btb/btb_4way.sv
`timescale 1ns/1ns

module btb_4way
    import bp_pkg::*;
#(
    parameter int btb_sets = default_btb_sets
) (
    input  logic clk,
    input  logic rst_n,
    input  pc_t  predict_pc,                        // fetch pc from IF
    input  pc_t  update_pc,                         // resolved branch pc from EX
    input  logic valid,                             // branch, jal, jalr resolved this cycle
    input  pc_t  target_pc,                         // resolved target from EX
    output pc_t  predicted_target,                  // buffered target for predict_pc
    output logic target_hit                         // predict_pc found in the buffer
);

    localparam int idx_w = idx_bits(btb_sets);
    localparam int tag_w = tag_bits(btb_sets);

    // storage, tags and targets are payload only
    logic [tag_w-1:0]    tag_mem    [btb_sets][btb_ways];
    pc_t                 target_mem [btb_sets][btb_ways];
    logic [btb_ways-1:0] way_vld    [btb_sets];     // one valid bit per way
    logic [2:0]          plru_q     [btb_sets];     // {right leaf, left leaf, root}

    // lookup side
    logic [idx_w-1:0]    pred_idx;
    logic [tag_w-1:0]    pred_tag;
    logic [btb_ways-1:0] pred_hit;

    // update side
    logic [idx_w-1:0]    upd_idx;
    logic [tag_w-1:0]    upd_tag;
    logic [btb_ways-1:0] upd_hit;
    logic [1:0]          hit_way;                   // way that matched the update tag
    logic [1:0]          free_way;                  // lowest invalid way in the set
    logic                has_free;
    logic [1:0]          victim_way;                // pseudo-lru choice when the set is full
    logic [1:0]          upd_way;                   // way written by this update
    logic [2:0]          plru_set;
    logic [2:0]          plru_next;

    assign pred_idx = predict_pc[idx_w+1:2];        // set index just above the byte offset
    assign pred_tag = predict_pc[xlen-1:idx_w+2];
    assign upd_idx  = update_pc[idx_w+1:2];
    assign upd_tag  = update_pc[xlen-1:idx_w+2];

    // parallel compare of all four ways, hits are one-hot so an or-mux is enough
    always_comb begin
        predicted_target = '0;
        for (int w = 0; w < btb_ways; w++) begin
            pred_hit[w] = way_vld[pred_idx][w] && (tag_mem[pred_idx][w] == pred_tag);
            if (pred_hit[w]) begin
                predicted_target = predicted_target | target_mem[pred_idx][w];
            end
        end
    end

    assign target_hit = |pred_hit;

    // update way selection: hit, then first free, then plru victim
    always_comb begin
        hit_way  = 2'd0;
        free_way = 2'd0;
        for (int w = 0; w < btb_ways; w++) begin
            upd_hit[w] = way_vld[upd_idx][w] && (tag_mem[upd_idx][w] == upd_tag);
            if (upd_hit[w]) begin
                hit_way = 2'(w);
            end
        end
        for (int w = btb_ways - 1; w >= 0; w--) begin   // descending so the lowest wins
            if (!way_vld[upd_idx][w]) begin
                free_way = 2'(w);
            end
        end
    end

    assign has_free = ~&way_vld[upd_idx];
    assign plru_set = plru_q[upd_idx];

    // root 0 points at pair {0,1}, leaf 0 points at the lower way of its pair
    assign victim_way = plru_set[0] ? {1'b1, plru_set[2]} : {1'b0, plru_set[1]};

    always_comb begin
        if (|upd_hit) begin
            upd_way = hit_way;                      // rewrite target in place
        end else if (has_free) begin
            upd_way = free_way;
        end else begin
            upd_way = victim_way;
        end
    end

    // turn the path bits away from the way just written
    always_comb begin
        plru_next    = plru_set;
        plru_next[0] = ~upd_way[1];                 // root points at the other pair
        if (upd_way[1]) begin
            plru_next[2] = ~upd_way[0];
        end else begin
            plru_next[1] = ~upd_way[0];
        end
    end

    // control state, only updates touch the plru bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < btb_sets; s++) begin
                way_vld[s] <= '0;
                plru_q[s]  <= '0;
            end
        end else if (valid) begin
            way_vld[upd_idx][upd_way] <= 1'b1;
            plru_q[upd_idx]           <= plru_next;
        end
    end

    // every resolved branch is written, taken or not
    always_ff @(posedge clk) begin
        if (valid) begin
            tag_mem[upd_idx][upd_way]    <= upd_tag;
            target_mem[upd_idx][upd_way] <= target_pc;
        end
    end

    // a tag lives in at most one way of its set, so both compares stay one-hot
    a_pred_hit_onehot : assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(pred_hit)
    ) else $error("btb lookup hit more than one way");

    a_upd_hit_onehot : assert property (
        @(posedge clk) disable iff (!rst_n) valid |-> $onehot0(upd_hit)
    ) else $error("btb update hit more than one way");

endmodule

// File: common/bp_pkg.sv
package bp_pkg;

    localparam int xlen = 32;                       // pc width, one word
    localparam int btb_ways = 4;                    // fixed associativity of the target buffer

    localparam int default_btb_sets    = 16;        // power of two
    localparam int default_bht_entries = 64;        // per-branch history slots
    localparam int default_hist_bits   = 4;         // local history length

    typedef logic [xlen-1:0] pc_t;

    // two-bit saturating counter, msb set means predict taken
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,                          // reset state
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } cnt_state_t;

    // index width for a table, at least one bit so slices stay legal
    function automatic int idx_bits(input int entries);
        int w;
        w = (entries > 1) ? $clog2(entries) : 1;
        return w;
    endfunction

    // tag width left over once bits 1:0 and the set index are removed
    function automatic int tag_bits(input int sets);
        int w;
        w = xlen - 2 - idx_bits(sets);
        return w;
    endfunction

endpackage
